// ==== Makefile ====
# Verilator build and run for the reorder buffer testbench

SRCS = $(wildcard design/*.sv design/*.svh test/*.sv)

all: run

obj_dir/Vrob_tb: verilog.f $(SRCS)
	verilator --binary --timing --assert -j 0 -f verilog.f --top-module rob_tb

# Status comes from the search for the pass line
run: obj_dir/Vrob_tb
	./obj_dir/Vrob_tb | tee /dev/stderr | grep -q "TEST PASS"

lint:
	verilator --lint-only --timing --assert -f verilog.f --top-module rob_tb

clean:
	rm -rf obj_dir

.PHONY: all run lint clean

// ==== design/rob_entries.sv ====
// Reorder buffer entry array
// Dispatch window decode and slot write
// CDB match for completion and branch outcome capture
// Clear on retire and on flush

`timescale 1ns/1ps
`default_nettype none

`include "rob_params.svh"

module rob_entries (
    input  logic                                     clk_i,
    input  logic                                     rst_i,
    rob_ptr_if.entries                               ent_if,
    input  rob_pkg::arch_reg_t  [`DP_NUM-1:0]        dp_rd_i,
    input  rob_pkg::tag_t       [`DP_NUM-1:0]        dp_tag_i,
    input  rob_pkg::tag_t       [`DP_NUM-1:0]        dp_tag_old_i,
    input  logic                [`DP_NUM-1:0]        dp_br_predict_i,
    input  logic                [`CDB_NUM-1:0]       cdb_valid_i,
    input  rob_pkg::rob_idx_t   [`CDB_NUM-1:0]       cdb_rob_idx_i,
    input  logic                [`CDB_NUM-1:0]       cdb_br_result_i,
    input  rob_pkg::addr_t      [`CDB_NUM-1:0]       cdb_br_target_i,
    output rob_pkg::rob_entry_t [`ROB_ENTRY_NUM-1:0] entries_o,
    output rob_pkg::rob_idx_t   [`DP_NUM-1:0]        rob_idx_o
);
    import rob_pkg::*;

    localparam int unsigned ENTRY_NUM = `ROB_ENTRY_NUM;
    localparam int unsigned SLOT_NUM  = `DP_NUM;
    localparam int unsigned CDB_CH    = `CDB_NUM;
    // Dispatch slot select width
    localparam int SLOT_W = (`DP_NUM > 1) ? $clog2(`DP_NUM) : 1;

    rob_entry_t [ENTRY_NUM-1:0] ent_q;
    logic       [ENTRY_NUM-1:0] dp_sel;
    logic       [SLOT_W-1:0]    dp_slot   [ENTRY_NUM];
    logic       [ENTRY_NUM-1:0] rt_sel;
    logic       [ENTRY_NUM-1:0] cp_sel;
    logic       [ENTRY_NUM-1:0] cp_result;
    addr_t                      cp_target [ENTRY_NUM];

    // --------------------------------------------------
    // Dispatch and retire windows
    // --------------------------------------------------
    always_comb begin
        int unsigned dp_off;
        int unsigned rt_off;
        for (int unsigned e = 0; e < ENTRY_NUM; e++) begin
            // Offset of entry from tail picks the slot
            dp_off     = idx_dist(ent_if.tail, rob_idx_t'(e));
            dp_sel[e]  = dp_off < 32'(ent_if.dp_num);
            dp_slot[e] = SLOT_W'(dp_off);
            // Retire window is rt_num entries from head
            rt_off     = idx_dist(ent_if.head, rob_idx_t'(e));
            rt_sel[e]  = rt_off < 32'(ent_if.rt_num);
        end
    end

    // Indexes handed back to the dispatcher
    always_comb begin
        for (int unsigned k = 0; k < SLOT_NUM; k++) begin
            rob_idx_o[k] = idx_add(ent_if.tail, k);
        end
    end

    // --------------------------------------------------
    // Completion match
    // --------------------------------------------------
    always_comb begin
        cp_sel    = '0;
        cp_result = '0;
        for (int unsigned e = 0; e < ENTRY_NUM; e++) begin
            cp_target[e] = '0;
            for (int unsigned c = 0; c < CDB_CH; c++) begin
                if (cdb_valid_i[c] && (cdb_rob_idx_i[c] == rob_idx_t'(e))) begin
                    cp_sel[e]    = 1'b1;
                    cp_result[e] = cdb_br_result_i[c];
                    cp_target[e] = cdb_br_target_i[c];
                end
            end
        end
    end

    // --------------------------------------------------
    // Entry update
    // --------------------------------------------------
    always_ff @(posedge clk_i) begin
        for (int unsigned e = 0; e < ENTRY_NUM; e++) begin
            if (rst_i || ent_if.flush) begin
                ent_q[e].valid    <= 1'b0;
                ent_q[e].complete <= 1'b0;
            end else if (dp_sel[e]) begin
                // Overrides a retire of the same slot, entry is reused
                ent_q[e].valid      <= 1'b1;
                ent_q[e].complete   <= 1'b0;
                ent_q[e].rd         <= dp_rd_i[dp_slot[e]];
                ent_q[e].tag        <= dp_tag_i[dp_slot[e]];
                ent_q[e].tag_old    <= dp_tag_old_i[dp_slot[e]];
                ent_q[e].br_predict <= dp_br_predict_i[dp_slot[e]];
                // Until completion, assume the prediction holds
                ent_q[e].br_result  <= dp_br_predict_i[dp_slot[e]];
            end else if (rt_sel[e]) begin
                ent_q[e].valid    <= 1'b0;
                ent_q[e].complete <= 1'b0;
            end else if (cp_sel[e] && ent_q[e].valid) begin
                ent_q[e].complete  <= 1'b1;
                ent_q[e].br_result <= cp_result[e];
                ent_q[e].br_target <= cp_target[e];
            end
        end
    end

    assign entries_o = ent_q;

    // Two channels never complete the same entry in one cycle
    for (genvar i = 0; i < `CDB_NUM; i++) begin : g_cdb_i
        for (genvar j = i + 1; j < `CDB_NUM; j++) begin : g_cdb_j
            cdb_idx_unique_a : assert property (@(posedge clk_i) disable iff (rst_i)
                !(cdb_valid_i[i] && cdb_valid_i[j] &&
                  (cdb_rob_idx_i[i] == cdb_rob_idx_i[j])));
        end
    end

endmodule

`default_nettype wire

// ==== design/rob_params.svh ====
// Reorder buffer sizing macros
// Entry count, dispatch, completion and retire widths
// Register file sizes and branch target width
// Index and count widths derived from the sizes above

`ifndef ROB_PARAMS_SVH
`define ROB_PARAMS_SVH

// Base sizes
`define ROB_ENTRY_NUM   8
`define DP_NUM          2
`define CDB_NUM         2
`define RT_NUM          2
`define ARCH_REG_NUM    32
`define PHY_REG_NUM     64
`define XLEN            32

// Derived widths
`define ROB_IDX_W       $clog2(`ROB_ENTRY_NUM)
`define TAG_W           $clog2(`PHY_REG_NUM)
`define ARCH_IDX_W      $clog2(`ARCH_REG_NUM)
// Counts run 0..N inclusive, hence the +1
`define DP_CNT_W        $clog2(`DP_NUM + 1)
`define RT_CNT_W        $clog2(`RT_NUM + 1)

`endif

// ==== design/rob_pkg.sv ====
// Reorder buffer package
// Index, tag, register, address and count types
// Stored entry layout
// Circular index helpers shared by the pointer, entry and retire blocks

`default_nettype none

`include "rob_params.svh"

package rob_pkg;

    typedef logic [`ROB_IDX_W-1:0]  rob_idx_t;
    typedef logic [`TAG_W-1:0]      tag_t;
    typedef logic [`ARCH_IDX_W-1:0] arch_reg_t;
    typedef logic [`XLEN-1:0]       addr_t;
    typedef logic [`DP_CNT_W-1:0]   dp_cnt_t;
    typedef logic [`RT_CNT_W-1:0]   rt_cnt_t;

    // One buffer slot
    typedef struct packed {
        logic      valid;
        logic      complete;
        arch_reg_t rd;
        tag_t      tag;
        tag_t      tag_old;
        logic      br_predict;
        // Actual direction, written at completion
        logic      br_result;
        addr_t     br_target;
    } rob_entry_t;

    // (base + off) modulo entry count, off below entry count
    function automatic rob_idx_t idx_add(rob_idx_t base, int unsigned off);
        int unsigned sum;
        sum = 32'(base) + off;
        if (sum >= `ROB_ENTRY_NUM) begin
            sum = sum - `ROB_ENTRY_NUM;
        end
        return rob_idx_t'(sum);
    endfunction

    // Distance from 'from' forward to 'to' around the ring
    function automatic int unsigned idx_dist(rob_idx_t from, rob_idx_t to);
        int unsigned d;
        d = 32'(to) + `ROB_ENTRY_NUM - 32'(from);
        if (d >= `ROB_ENTRY_NUM) begin
            d = d - `ROB_ENTRY_NUM;
        end
        return d;
    endfunction

endpackage

`default_nettype wire

// ==== design/rob_ptr.sv ====
// Reorder buffer pointer block
// Head and tail registers with wrap bits
// Free entry count and dispatch availability

`timescale 1ns/1ps
`default_nettype none

`include "rob_params.svh"

module rob_ptr (
    input  logic             clk_i,
    input  logic             rst_i,
    rob_ptr_if.ptr           ptr_if,
    output rob_pkg::dp_cnt_t avail_num_o
);
    import rob_pkg::*;

    localparam int unsigned ENTRY_NUM = `ROB_ENTRY_NUM;
    localparam int unsigned DP_MAX    = `DP_NUM;
    // Room for entry count plus retire count
    localparam int CNT_W = `ROB_IDX_W + 2;

    rob_idx_t         head_q;
    rob_idx_t         tail_q;
    logic             head_wrap_q;
    logic             tail_wrap_q;
    rob_idx_t         head_d;
    rob_idx_t         tail_d;
    logic             head_wrap_d;
    logic             tail_wrap_d;
    logic [CNT_W-1:0] free_cnt;
    logic [CNT_W-1:0] room_cnt;

    // --------------------------------------------------
    // Next pointers
    // --------------------------------------------------
    always_comb begin
        int unsigned head_sum;
        int unsigned tail_sum;
        head_sum    = 32'(head_q) + 32'(ptr_if.rt_num);
        tail_sum    = 32'(tail_q) + 32'(ptr_if.dp_num);
        head_d      = idx_add(head_q, 32'(ptr_if.rt_num));
        tail_d      = idx_add(tail_q, 32'(ptr_if.dp_num));
        // Wrap bit flips each time a pointer passes the last entry
        head_wrap_d = head_wrap_q ^ (head_sum >= ENTRY_NUM);
        tail_wrap_d = tail_wrap_q ^ (tail_sum >= ENTRY_NUM);
    end

    always_ff @(posedge clk_i) begin
        if (rst_i || ptr_if.flush) begin
            head_q      <= '0;
            tail_q      <= '0;
            head_wrap_q <= 1'b0;
            tail_wrap_q <= 1'b0;
        end else begin
            head_q      <= head_d;
            tail_q      <= tail_d;
            head_wrap_q <= head_wrap_d;
            tail_wrap_q <= tail_wrap_d;
        end
    end

    // --------------------------------------------------
    // Availability
    // --------------------------------------------------
    always_comb begin
        // Same lap: used = tail - head; different lap: tail behind head
        if (head_wrap_q == tail_wrap_q) begin
            free_cnt = CNT_W'(ENTRY_NUM) - CNT_W'(tail_q) + CNT_W'(head_q);
        end else begin
            free_cnt = CNT_W'(head_q) - CNT_W'(tail_q);
        end
        // Entries retiring now are reusable this cycle
        room_cnt = free_cnt + CNT_W'(ptr_if.rt_num);
        if (room_cnt > CNT_W'(DP_MAX)) begin
            avail_num_o = dp_cnt_t'(DP_MAX);
        end else begin
            avail_num_o = dp_cnt_t'(room_cnt);
        end
    end

    assign ptr_if.head = head_q;
    assign ptr_if.tail = tail_q;

    // Dispatcher must respect the advertised room
    dp_within_avail_a : assert property (@(posedge clk_i) disable iff (rst_i)
        ptr_if.dp_num <= avail_num_o);

endmodule

`default_nettype wire

// ==== design/rob_ptr_if.sv ====
// Pointer bundle between the reorder buffer blocks
// Head and tail pointers, dispatch and retire counts, flush
// Modports for the pointer, entry array and retire blocks

`timescale 1ns/1ps
`default_nettype none

interface rob_ptr_if;
    import rob_pkg::*;

    // Oldest entry and next free slot
    rob_idx_t head;
    rob_idx_t tail;
    // Entries written and retired this cycle
    dp_cnt_t  dp_num;
    rt_cnt_t  rt_num;
    // Whole buffer discard, takes effect at next edge
    logic     flush;

    modport ptr (
        output head, tail,
        input  dp_num, rt_num, flush
    );

    modport entries (
        input head, tail, dp_num, rt_num, flush
    );

    modport retire (
        input  head,
        output rt_num, flush
    );

endinterface

`default_nettype wire

// ==== design/rob_retire.sv ====
// Reorder buffer retire logic
// In-order completed prefix across the retire window
// Retire lane fields for the map table and free list
// Mispredict detection and flush generation

`timescale 1ns/1ps
`default_nettype none

`include "rob_params.svh"

module rob_retire (
    input  logic                                     exception_i,
    input  rob_pkg::rob_entry_t [`ROB_ENTRY_NUM-1:0] entries_i,
    rob_ptr_if.retire                                rt_if,
    output logic                [`RT_NUM-1:0]        rt_valid_o,
    output rob_pkg::arch_reg_t  [`RT_NUM-1:0]        rt_arch_reg_o,
    output rob_pkg::tag_t       [`RT_NUM-1:0]        rt_phy_reg_o,
    output rob_pkg::tag_t       [`RT_NUM-1:0]        rt_tag_old_o,
    output logic                                     br_mis_valid_o,
    output rob_pkg::addr_t                           br_target_o
);
    import rob_pkg::*;

    localparam int unsigned LANE_NUM = `RT_NUM;

    // Lane j sees entry head + j
    rob_entry_t [LANE_NUM-1:0] lane_ent;
    logic       [LANE_NUM-1:0] lane_mis;
    // chain[j] high when every older lane retires cleanly
    logic       [LANE_NUM:0]   chain;
    rt_cnt_t                   rt_cnt;

    // --------------------------------------------------
    // Retire window
    // --------------------------------------------------
    always_comb begin
        for (int unsigned j = 0; j < LANE_NUM; j++) begin
            lane_ent[j] = entries_i[idx_add(rt_if.head, j)];
        end
    end

    always_comb begin
        // Exception blocks every lane
        chain[0] = !exception_i;
        for (int unsigned j = 0; j < LANE_NUM; j++) begin
            rt_valid_o[j] = chain[j] && lane_ent[j].valid && lane_ent[j].complete;
            lane_mis[j]   = rt_valid_o[j] &&
                            (lane_ent[j].br_predict != lane_ent[j].br_result);
            // Lanes younger than a mispredict stay low
            chain[j+1]    = rt_valid_o[j] && !lane_mis[j];
        end
    end

    // Lane payload is meaningful only where rt_valid_o is high
    always_comb begin
        for (int unsigned j = 0; j < LANE_NUM; j++) begin
            rt_arch_reg_o[j] = lane_ent[j].rd;
            rt_phy_reg_o[j]  = lane_ent[j].tag;
            rt_tag_old_o[j]  = lane_ent[j].tag_old;
        end
    end

    // Thermometer to count
    always_comb begin
        rt_cnt = '0;
        for (int unsigned j = 0; j < LANE_NUM; j++) begin
            if (rt_valid_o[j]) begin
                rt_cnt = rt_cnt + rt_cnt_t'(1);
            end
        end
    end

    // --------------------------------------------------
    // Mispredict and flush
    // --------------------------------------------------
    always_comb begin
        br_mis_valid_o = 1'b0;
        br_target_o    = '0;
        // Oldest mispredicted lane wins
        for (int unsigned j = 0; j < LANE_NUM; j++) begin
            if (lane_mis[j] && !br_mis_valid_o) begin
                br_mis_valid_o = 1'b1;
                br_target_o    = lane_ent[j].br_target;
            end
        end
    end

    assign rt_if.rt_num = rt_cnt;
    assign rt_if.flush  = exception_i || br_mis_valid_o;

endmodule

`default_nettype wire

// ==== design/rob_top.sv ====
// Reorder buffer top level
// Pointer bundle, pointer block, entry array and retire logic
// Dispatch, CDB and retire ports

`timescale 1ns/1ps
`default_nettype none

`include "rob_params.svh"

module rob_top (
    input  logic                                clk_i,
    input  logic                                rst_i,
    input  logic                                exception_i,
    // Dispatch
    input  rob_pkg::dp_cnt_t                    dp_num_i,
    input  rob_pkg::arch_reg_t [`DP_NUM-1:0]    dp_rd_i,
    input  rob_pkg::tag_t      [`DP_NUM-1:0]    dp_tag_i,
    input  rob_pkg::tag_t      [`DP_NUM-1:0]    dp_tag_old_i,
    input  logic               [`DP_NUM-1:0]    dp_br_predict_i,
    output rob_pkg::dp_cnt_t                    avail_num_o,
    output rob_pkg::rob_idx_t  [`DP_NUM-1:0]    rob_idx_o,
    // Completion
    input  logic               [`CDB_NUM-1:0]   cdb_valid_i,
    input  rob_pkg::rob_idx_t  [`CDB_NUM-1:0]   cdb_rob_idx_i,
    input  logic               [`CDB_NUM-1:0]   cdb_br_result_i,
    input  rob_pkg::addr_t     [`CDB_NUM-1:0]   cdb_br_target_i,
    // Retire
    output logic               [`RT_NUM-1:0]    rt_valid_o,
    output rob_pkg::arch_reg_t [`RT_NUM-1:0]    rt_arch_reg_o,
    output rob_pkg::tag_t      [`RT_NUM-1:0]    rt_phy_reg_o,
    output rob_pkg::tag_t      [`RT_NUM-1:0]    rt_tag_old_o,
    // Redirect
    output logic                                br_mis_valid_o,
    output rob_pkg::addr_t                      br_target_o
);
    import rob_pkg::*;

    // Full array snapshot for the retire window
    rob_entry_t [`ROB_ENTRY_NUM-1:0] entries;

    rob_ptr_if u_ptr_if ();

    assign u_ptr_if.dp_num = dp_num_i;

    rob_ptr u_rob_ptr (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .ptr_if      (u_ptr_if.ptr),
        .avail_num_o (avail_num_o)
    );

    rob_entries u_rob_entries (
        .clk_i           (clk_i),
        .rst_i           (rst_i),
        .ent_if          (u_ptr_if.entries),
        .dp_rd_i         (dp_rd_i),
        .dp_tag_i        (dp_tag_i),
        .dp_tag_old_i    (dp_tag_old_i),
        .dp_br_predict_i (dp_br_predict_i),
        .cdb_valid_i     (cdb_valid_i),
        .cdb_rob_idx_i   (cdb_rob_idx_i),
        .cdb_br_result_i (cdb_br_result_i),
        .cdb_br_target_i (cdb_br_target_i),
        .entries_o       (entries),
        .rob_idx_o       (rob_idx_o)
    );

    rob_retire u_rob_retire (
        .exception_i    (exception_i),
        .entries_i      (entries),
        .rt_if          (u_ptr_if.retire),
        .rt_valid_o     (rt_valid_o),
        .rt_arch_reg_o  (rt_arch_reg_o),
        .rt_phy_reg_o   (rt_phy_reg_o),
        .rt_tag_old_o   (rt_tag_old_o),
        .br_mis_valid_o (br_mis_valid_o),
        .br_target_o    (br_target_o)
    );

endmodule

`default_nettype wire

// ==== test/rob_tb.sv ====
// Reorder buffer testbench
// Random dispatch, completion, mispredict and exception stimulus
// Queue model of the buffer with in-order retire
// Compare tasks for counts, indexes, retire lanes and redirects

`timescale 1ns/1ps
`default_nettype none

`include "rob_params.svh"

module rob_tb;
    import rob_pkg::*;

    localparam int unsigned ENTRY_NUM     = `ROB_ENTRY_NUM;
    localparam int unsigned DP            = `DP_NUM;
    localparam int unsigned CDB           = `CDB_NUM;
    localparam int unsigned RT            = `RT_NUM;
    localparam int unsigned RUN_CYCLES    = 3000;
    localparam int unsigned RESET_TIMEOUT = 20;
    localparam int unsigned DRAIN_TIMEOUT = 200;

    logic                    clk_i;
    logic                    rst_i;
    logic                    exception_i;
    dp_cnt_t                 dp_num_i;
    arch_reg_t [DP-1:0]      dp_rd_i;
    tag_t      [DP-1:0]      dp_tag_i;
    tag_t      [DP-1:0]      dp_tag_old_i;
    logic      [DP-1:0]      dp_br_predict_i;
    logic      [CDB-1:0]     cdb_valid_i;
    rob_idx_t  [CDB-1:0]     cdb_rob_idx_i;
    logic      [CDB-1:0]     cdb_br_result_i;
    addr_t     [CDB-1:0]     cdb_br_target_i;
    dp_cnt_t                 avail_num_o;
    rob_idx_t  [DP-1:0]      rob_idx_o;
    logic      [RT-1:0]      rt_valid_o;
    arch_reg_t [RT-1:0]      rt_arch_reg_o;
    tag_t      [RT-1:0]      rt_phy_reg_o;
    tag_t      [RT-1:0]      rt_tag_old_o;
    logic                    br_mis_valid_o;
    addr_t                   br_target_o;

    // Model state with the oldest entry at the front
    rob_entry_t              model_q[$];
    rob_idx_t                model_head;
    logic [31:0]             lfsr_state;
    // Inputs presented in the current cycle
    logic                    cur_exc;
    int unsigned             cur_dp_num;
    arch_reg_t [DP-1:0]      cur_rd;
    tag_t      [DP-1:0]      cur_tag;
    tag_t      [DP-1:0]      cur_old;
    logic      [DP-1:0]      cur_pred;
    logic      [CDB-1:0]     cur_cdb_v;
    rob_idx_t  [CDB-1:0]     cur_cdb_idx;
    logic      [CDB-1:0]     cur_cdb_res;
    addr_t     [CDB-1:0]     cur_cdb_tgt;
    // Expected responses for the current cycle
    logic      [RT-1:0]      exp_rt_valid;
    int unsigned             exp_rt_cnt;
    logic                    exp_mis;
    addr_t                   exp_target;
    dp_cnt_t                 exp_avail;

    rob_top u_rob_top (.*);

    initial begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;
    end

    // --------------------------------------------------
    // Random source and ring arithmetic
    // --------------------------------------------------
    function automatic logic [31:0] rand_bits(input int unsigned n);
        logic [31:0] r;
        r = '0;
        for (int unsigned i = 0; i < n; i++) begin
            // One Galois step per bit taken
            if (lfsr_state[0]) begin
                lfsr_state = (lfsr_state >> 1) ^ 32'h8020_0003;
            end else begin
                lfsr_state = lfsr_state >> 1;
            end
            r = {r[30:0], lfsr_state[0]};
        end
        return r;
    endfunction

    function automatic rob_idx_t ring_add(input rob_idx_t base, input int unsigned off);
        return rob_idx_t'((32'(base) + off) % ENTRY_NUM);
    endfunction

    // --------------------------------------------------
    // Error reporting and compare tasks
    // --------------------------------------------------
    task automatic stop_with_error(input string msg);
        $display("%s", msg);
        $display("TEST FAIL");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic check_count(input string name, input dp_cnt_t got, input dp_cnt_t exp);
        if (got !== exp) begin
            stop_with_error($sformatf("Fail %s: got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_idx(input string name, input rob_idx_t got, input rob_idx_t exp);
        if (got !== exp) begin
            stop_with_error($sformatf("Fail %s: got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_lane(input int unsigned j, input logic got_v, input arch_reg_t got_rd,
                              input tag_t got_tag, input tag_t got_old,
                              input logic exp_v, input rob_entry_t exp_ent);
        if (got_v !== exp_v) begin
            stop_with_error($sformatf("Fail rt_valid_o[%0d]: got %h expected %h",
                                      j, got_v, exp_v));
        end else if (exp_v) begin
            if (got_rd !== exp_ent.rd) begin
                stop_with_error($sformatf("Fail rt_arch_reg_o[%0d]: got %h expected %h",
                                          j, got_rd, exp_ent.rd));
            end
            if (got_tag !== exp_ent.tag) begin
                stop_with_error($sformatf("Fail rt_phy_reg_o[%0d]: got %h expected %h",
                                          j, got_tag, exp_ent.tag));
            end
            if (got_old !== exp_ent.tag_old) begin
                stop_with_error($sformatf("Fail rt_tag_old_o[%0d]: got %h expected %h",
                                          j, got_old, exp_ent.tag_old));
            end
        end
    endtask

    task automatic check_branch(input logic got_v, input addr_t got_tgt,
                                input logic exp_v, input addr_t exp_tgt);
        if (got_v !== exp_v) begin
            stop_with_error($sformatf("Fail br_mis_valid_o: got %h expected %h", got_v, exp_v));
        end else if (exp_v && (got_tgt !== exp_tgt)) begin
            stop_with_error($sformatf("Fail br_target_o: got %h expected %h", got_tgt, exp_tgt));
        end
    endtask

    // --------------------------------------------------
    // Model
    // --------------------------------------------------
    // Leading completed run from the head that stops after a mispredict
    task automatic predict_retire();
        logic run;
        run        = !cur_exc;
        exp_rt_cnt = 0;
        exp_mis    = 1'b0;
        exp_target = '0;
        for (int unsigned j = 0; j < RT; j++) begin
            exp_rt_valid[j] = 1'b0;
            if (run && (j < model_q.size()) && model_q[j].complete) begin
                exp_rt_valid[j] = 1'b1;
                exp_rt_cnt++;
                if (model_q[j].br_predict != model_q[j].br_result) begin
                    exp_mis    = 1'b1;
                    exp_target = model_q[j].br_target;
                    run        = 1'b0;
                end
            end else begin
                run = 1'b0;
            end
        end
    endtask

    // State change at the clock edge for the inputs of the ending cycle
    task automatic apply_edge();
        int unsigned pos;
        rob_entry_t  ent;
        logic        flushed;
        flushed = cur_exc || exp_mis;
        if (flushed) begin
            model_q.delete();
            model_head = '0;
        end else begin
            for (int unsigned c = 0; c < CDB; c++) begin
                pos = (32'(cur_cdb_idx[c]) + ENTRY_NUM - 32'(model_head)) % ENTRY_NUM;
                if (cur_cdb_v[c] && (pos < model_q.size())) begin
                    model_q[pos].complete  = 1'b1;
                    model_q[pos].br_result = cur_cdb_res[c];
                    model_q[pos].br_target = cur_cdb_tgt[c];
                end
            end
            for (int unsigned j = 0; j < exp_rt_cnt; j++) begin
                void'(model_q.pop_front());
                model_head = ring_add(model_head, 1);
            end
            for (int unsigned k = 0; k < cur_dp_num; k++) begin
                ent            = '0;
                ent.valid      = 1'b1;
                ent.rd         = cur_rd[k];
                ent.tag        = cur_tag[k];
                ent.tag_old    = cur_old[k];
                ent.br_predict = cur_pred[k];
                ent.br_result  = cur_pred[k];
                model_q.push_back(ent);
            end
        end
    endtask

    task automatic check_outputs();
        rob_entry_t lane_ent;
        check_count("avail_num_o", avail_num_o, exp_avail);
        for (int unsigned k = 0; k < DP; k++) begin
            check_idx($sformatf("rob_idx_o[%0d]", k), rob_idx_o[k],
                      ring_add(model_head, model_q.size() + k));
        end
        for (int unsigned j = 0; j < RT; j++) begin
            if (j < model_q.size()) begin
                lane_ent = model_q[j];
            end else begin
                lane_ent = '0;
            end
            check_lane(j, rt_valid_o[j], rt_arch_reg_o[j], rt_phy_reg_o[j], rt_tag_old_o[j],
                       exp_rt_valid[j], lane_ent);
        end
        check_branch(br_mis_valid_o, br_target_o, exp_mis, exp_target);
    endtask

    // --------------------------------------------------
    // One cycle of stimulus and checking
    // --------------------------------------------------
    task automatic run_cycle(input logic drain);
        int unsigned cand[$];
        int unsigned pick;
        int unsigned pos;
        int unsigned room;
        @(posedge clk_i);
        apply_edge();
        cur_exc = drain ? 1'b0 : (rand_bits(6) == 0);
        predict_retire();
        room      = ENTRY_NUM - model_q.size() + exp_rt_cnt;
        exp_avail = dp_cnt_t'((room > DP) ? DP : room);
        cur_dp_num = drain ? 0 : rand_bits(2) % (32'(exp_avail) + 1);
        for (int unsigned k = 0; k < DP; k++) begin
            cur_rd[k]   = arch_reg_t'(rand_bits(`ARCH_IDX_W));
            cur_tag[k]  = tag_t'(rand_bits(`TAG_W));
            cur_old[k]  = tag_t'(rand_bits(`TAG_W));
            cur_pred[k] = rand_bits(1) != 0;
        end
        // Each outstanding entry goes on at most one channel
        for (int unsigned p = 0; p < model_q.size(); p++) begin
            if (!model_q[p].complete) begin
                cand.push_back(p);
            end
        end
        cur_cdb_v = '0;
        for (int unsigned c = 0; c < CDB; c++) begin
            if ((cand.size() > 0) && (drain || (rand_bits(1) != 0))) begin
                pick = rand_bits(3) % cand.size();
                pos  = cand[pick];
                cand.delete(pick);
                cur_cdb_v[c]   = 1'b1;
                cur_cdb_idx[c] = ring_add(model_head, pos);
                // About one in ten resolves against the prediction
                cur_cdb_res[c] = model_q[pos].br_predict ^ (!drain && (rand_bits(7) < 13));
                cur_cdb_tgt[c] = addr_t'(rand_bits(`XLEN));
            end
        end
        exception_i     <= cur_exc;
        dp_num_i        <= dp_cnt_t'(cur_dp_num);
        dp_rd_i         <= cur_rd;
        dp_tag_i        <= cur_tag;
        dp_tag_old_i    <= cur_old;
        dp_br_predict_i <= cur_pred;
        cdb_valid_i     <= cur_cdb_v;
        cdb_rob_idx_i   <= cur_cdb_idx;
        cdb_br_result_i <= cur_cdb_res;
        cdb_br_target_i <= cur_cdb_tgt;
        @(negedge clk_i);
        check_outputs();
    endtask

    // --------------------------------------------------
    // Main sequence
    // --------------------------------------------------
    initial begin
        int unsigned wait_cnt;
        lfsr_state = 32'd74;
        rst_i = 1'b1;
        exception_i = 1'b0;
        dp_num_i = '0;
        dp_rd_i = '0;
        dp_tag_i = '0;
        dp_tag_old_i = '0;
        dp_br_predict_i = '0;
        cdb_valid_i = '0;
        cdb_rob_idx_i = '0;
        cdb_br_result_i = '0;
        cdb_br_target_i = '0;
        cur_exc = 1'b0;
        cur_dp_num = 0;
        cur_cdb_v = '0;
        cur_cdb_idx = '0;
        cur_cdb_res = '0;
        cur_cdb_tgt = '0;
        exp_rt_cnt = 0;
        exp_mis = 1'b0;
        model_head = '0;
        for (int unsigned i = 0; i < 8; i++) begin
            @(posedge clk_i);
        end
        rst_i <= 1'b0;
        // Outputs settle to known values out of reset
        wait_cnt = 0;
        @(negedge clk_i);
        while ($isunknown({avail_num_o, rt_valid_o, br_mis_valid_o})) begin
            if (wait_cnt == RESET_TIMEOUT) begin
                stop_with_error("Outputs stayed unknown after reset");
            end
            wait_cnt++;
            @(negedge clk_i);
        end
        check_count("avail_num_o", avail_num_o, dp_cnt_t'(DP));
        for (int unsigned j = 0; j < RT; j++) begin
            check_lane(j, rt_valid_o[j], rt_arch_reg_o[j], rt_phy_reg_o[j], rt_tag_old_o[j],
                       1'b0, '0);
        end
        check_branch(br_mis_valid_o, br_target_o, 1'b0, '0);

        for (int unsigned n = 0; n < RUN_CYCLES; n++) begin
            run_cycle(1'b0);
        end

        // Drain by completing everything left
        wait_cnt = 0;
        while (model_q.size() != 0) begin
            if (wait_cnt == DRAIN_TIMEOUT) begin
                stop_with_error("Buffer did not drain within the time limit");
            end
            run_cycle(1'b1);
            wait_cnt++;
        end
        $display("TEST PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+design
design/rob_pkg.sv
design/rob_ptr_if.sv
design/rob_ptr.sv
design/rob_entries.sv
design/rob_retire.sv
design/rob_top.sv
test/rob_tb.sv
